//--- dma_spi_top.f
verilog/dma_reg_pkg.sv
verilog/dma_engine_pkg.sv
verilog/descriptor_ram.sv
verilog/dma_reg_file.sv
verilog/dma_sequencer.sv
verilog/dma_word_lane.sv
verilog/dma_addr_gen.sv
verilog/dma_spi_top.sv
verif/dma_checker.sv
verif/tb_dma_spi.sv

//--- run_sim.sh
#!/bin/sh
# compile the dma testbench with verilator, run it, and pass only on the pass message
cd "$(dirname "$0")" &&
verilator --binary -Wno-fatal --top-module tb_dma_spi -f dma_spi_top.f -o sim_dma &&
./obj_dir/sim_dma | tee /dev/stderr | grep -q "Done: no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/dma_checker.sv
module dma_checker (
    input logic                     fast_clk_i,
    input dma_engine_pkg::mem_req_t mem_req_i,
    input logic                     mem_ack_i,
    input logic                     tx_valid_i,
    input logic [7:0]               tx_data_i
);
    import dma_reg_pkg::*;

    int          value_errs = 0;
    int          other_errs = 0;
    // expected bus beats and transmit bytes, oldest first
    logic [17:0] exp_addr [$];
    logic [3:0]  exp_sel [$];
    logic        exp_we [$];
    logic [31:0] exp_data [$];
    logic [7:0]  exp_tx [$];

    // memory contents before any write, spread over the whole address
    function automatic logic [31:0] fill_word(input logic [17:0] a);
        return (32'(a) + 32'd1) * 32'h9e37_79b9;
    endfunction

    // walks the descriptor chain the way the engine should
    function automatic void build_expect(input dma_desc_t descs [4], input dma_ctrl_t ctrl,
                                         input logic [7:0] rx [16]);
        int          n;
        logic        chain_end;
        logic [17:0] a;
        logic [3:0]  s;
        logic [31:0] w;
        n         = 0;
        chain_end = 1'b0;
        // byte mode touches only the target lane
        s = ctrl.byte_mode ? (4'b0001 << ctrl.byte_target) : 4'b1111;
        for (int d = 0; d < 4 && !chain_end; d++) begin
            for (int b = 0; b <= int'(descs[d].len); b++) begin
                a = descs[d].incr ? descs[d].addr + 18'(b) : descs[d].addr;
                w = ctrl.dir ? 32'h0 : fill_word(a);
                // lanes go low first
                for (int l = 0; l < 4; l++) begin
                    if (s[l] && ctrl.dir) begin
                        w[8*l +: 8] = rx[n];
                        n++;
                    end else if (s[l]) begin
                        exp_tx.push_back(w[8*l +: 8]);
                    end
                end
                exp_addr.push_back(a);
                exp_sel.push_back(s);
                exp_we.push_back(ctrl.dir);
                exp_data.push_back(w);
            end
            chain_end = descs[d].last;
        end
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            value_errs++;
            $display("ERR %0t %s exp=%h got=%h", $time, name, exp, got);
        end
    endtask

    // one beat ends on each acked request
    always @(posedge fast_clk_i) begin
        logic [31:0] mask;
        if (mem_req_i.req && mem_ack_i) begin
            if (exp_addr.size() == 0) begin
                other_errs++;
                $display("%0t: a bus access happened with no transfer expected", $time);
            end else begin
                compare_value("mem_req_o.addr", 32'(mem_req_i.addr), 32'(exp_addr[0]));
                compare_value("mem_req_o.sel", 32'(mem_req_i.sel), 32'(exp_sel[0]));
                compare_value("mem_req_o.we", 32'(mem_req_i.we), 32'(exp_we[0]));
                // unselected lanes carry stale bytes
                for (int l = 0; l < 4; l++) begin
                    mask[8*l +: 8] = {8{exp_sel[0][l]}};
                end
                if (exp_we[0]) begin
                    compare_value("mem_req_o.wdata", mem_req_i.wdata & mask, exp_data[0] & mask);
                end
                void'(exp_addr.pop_front());
                void'(exp_sel.pop_front());
                void'(exp_we.pop_front());
                void'(exp_data.pop_front());
            end
        end
        if (tx_valid_i) begin
            if (exp_tx.size() == 0) begin
                other_errs++;
                $display("%0t: a transmit byte appeared with none expected", $time);
            end else begin
                compare_value("tx_data_o", 32'(tx_data_i), 32'(exp_tx.pop_front()));
            end
        end
    end

    // anything left over was never seen on the bus or the stream
    function automatic int report_errors();
        if (exp_addr.size() != 0 || exp_tx.size() != 0) begin
            other_errs++;
            $display("expected transfers were never seen: %0d beats, %0d bytes",
                     exp_addr.size(), exp_tx.size());
        end
        $display("error count: value %0d, other %0d", value_errs, other_errs);
        return value_errs + other_errs;
    endfunction

endmodule

//--- verif/tb_dma_spi.sv
module tb_dma_spi;
    import dma_reg_pkg::*;
    import dma_engine_pkg::*;

    // 11 beats over all runs
    localparam int WATCHDOG_CYCLES = 11 * 20 + 600;

    logic        clk;
    logic        rst;
    logic        reg_wr;
    logic        reg_rd;
    logic [7:0]  reg_addr;
    logic [31:0] reg_wdata;
    logic [3:0]  reg_be;
    logic [31:0] reg_rdata;
    logic        ext_trig;
    logic        dma_rdy;
    mem_req_t    mem_req;
    logic        mem_ack;
    logic [31:0] mem_rdata;
    logic        tx_valid;
    logic [7:0]  tx_data;
    logic        rx_valid;
    logic [7:0]  rx_data;
    logic        done;
    int          lat = 0;
    logic [31:0] mem_data [logic [17:0]];

    dma_spi_top #(
        .DESC_IDX_W(5)
    ) u_dma_spi_top (
        .fast_clk_i(clk), .dma_engine_reset(rst), .reg_wr_i(reg_wr), .reg_rd_i(reg_rd),
        .reg_addr_i(reg_addr), .reg_wdata_i(reg_wdata), .reg_be_i(reg_be),
        .reg_rdata_o(reg_rdata), .ext_trig_i(ext_trig), .dma_rdy_o(dma_rdy),
        .mem_req_o(mem_req), .mem_ack_i(mem_ack), .mem_rdata_i(mem_rdata),
        .tx_valid_o(tx_valid), .tx_data_o(tx_data), .rx_valid_i(rx_valid),
        .rx_data_i(rx_data), .done_o(done)
    );

    dma_checker u_chk (
        .fast_clk_i(clk), .mem_req_i(mem_req), .mem_ack_i(mem_ack),
        .tx_valid_i(tx_valid), .tx_data_i(tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
        void'(u_chk.report_errors());
        $display("Done: errors found");
        $finish;
    end

    // memory with a random ack latency of 1 to 3 cycles
    always @(negedge clk) begin
        mem_ack <= 1'b0;
        if (mem_req.req && !mem_ack) begin
            if (lat == 0) lat = $urandom_range(3, 1);
            lat = lat - 1;
            if (lat == 0) begin
                mem_ack   <= 1'b1;
                mem_rdata <= mem_data.exists(mem_req.addr) ? mem_data[mem_req.addr] :
                             u_chk.fill_word(mem_req.addr);
                if (mem_req.we) begin
                    mem_data[mem_req.addr] = mem_req.wdata;
                end
            end
        end
    end

    task automatic reg_write(input logic [7:0] a, input logic [31:0] d, input logic [3:0] be);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        reg_be    = be;
        @(negedge clk);
        reg_wr = 1'b0;
    endtask

    task automatic reg_read(input logic [7:0] a, output logic [31:0] d);
        reg_rd   = 1'b1;
        reg_addr = a;
        @(negedge clk);
        reg_rd = 1'b0;
        d      = reg_rdata;
    endtask

    // one byte per cycle, from the current falling edge on
    task automatic send_bytes(input logic [7:0] rx [16], input int first, input int n);
        for (int i = 0; i < n; i++) begin
            rx_valid = 1'b1;
            rx_data  = rx[first + i];
            @(negedge clk);
        end
        rx_valid = 1'b0;
    endtask

    // ack, then NEXT and DECODE, then the fetch state is live
    task automatic wait_fetch_after_ack();
        do @(posedge clk); while (!mem_ack);
        repeat (3) @(negedge clk);
    endtask

    task automatic wait_done_check(input int runs, input int last_idx);
        logic [31:0] rd;
        do @(posedge clk); while (!done);
        @(negedge clk);
        reg_read(8'(RUN_COUNT), rd);
        u_chk.compare_value("RUN_COUNT", rd, 32'(runs));
        reg_read(8'(CUR_DESC), rd);
        u_chk.compare_value("CUR_DESC", rd, 32'(last_idx));
    endtask

    function automatic logic [31:0] make_ctrl(input logic en, input logic ext, input logic dir,
                                              input logic bmode, input logic [1:0] tgt,
                                              input logic rxen);
        dma_ctrl_t c;
        c             = '0;
        c.enable      = en;
        c.ext_trig_en = ext;
        c.dir         = dir;
        c.byte_mode   = bmode;
        c.byte_target = tgt;
        c.rx_en       = rxen;
        return c;
    endfunction

    initial begin
        logic [31:0] rd;
        dma_desc_t   descs [4];
        logic [7:0]  rx [16];
        logic [7:0]  junk [16];
        void'($urandom(37));
        {rst, reg_wr, reg_rd, reg_addr, reg_wdata, reg_be} = {1'b1, 46'h0};
        {ext_trig, rx_valid, rx_data, mem_ack, mem_rdata} = '0;
        for (int i = 0; i < 16; i++) begin
            rx[i]   = 8'($urandom);
            junk[i] = 8'($urandom);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // descriptor readback with byte enables
        reg_write(8'h85, 32'hffff_ffff, 4'hf);
        reg_write(8'h85, 32'h1234_5678, 4'b0101);
        reg_read(8'h85, rd);
        u_chk.compare_value("desc[5]", rd, 32'hff34_ff78);

        // external trigger with the engine disabled
        ext_trig = 1'b1;
        @(negedge clk);
        ext_trig = 1'b0;
        repeat (10) @(negedge clk);
        u_chk.compare_value("dma_rdy_o", 32'(dma_rdy), 32'h0);

        // word mode memory to spi over a two descriptor chain
        descs = '{'{1'b0, 12'd2, 1'b1, 18'h10}, '{1'b1, 12'd1, 1'b1, 18'h40}, '0, '0};
        reg_write(8'h80, descs[0], 4'hf);
        reg_write(8'h81, descs[1], 4'hf);
        reg_write(8'(CTRL), make_ctrl(1, 0, 0, 0, 2'd0, 0), 4'b0011);
        // external trigger not allowed yet so the pin must not start a run
        ext_trig = 1'b1;
        @(negedge clk);
        ext_trig = 1'b0;
        repeat (10) @(negedge clk);
        u_chk.compare_value("dma_rdy_o", 32'(dma_rdy), 32'h0);
        reg_read(8'(CTRL), rd);
        u_chk.compare_value("CTRL", rd, make_ctrl(1, 0, 0, 0, 2'd0, 0));
        u_chk.build_expect(descs, make_ctrl(1, 0, 0, 0, 2'd0, 0), rx);
        reg_write(8'(CMD), 32'(1) << CMD_SOFT_TRIG_BIT, 4'hf);
        wait_done_check(1, 1);

        // byte mode spi to memory, fixed address, external trigger
        descs = '{'{1'b1, 12'd3, 1'b0, 18'h80}, '0, '0, '0};
        reg_write(8'h80, descs[0], 4'hf);
        reg_write(8'(CTRL), make_ctrl(1, 1, 1, 1, 2'd2, 1), 4'b0011);
        u_chk.compare_value("dma_rdy_o", 32'(dma_rdy), 32'h1);
        u_chk.build_expect(descs, make_ctrl(1, 1, 1, 1, 2'd2, 1), rx);
        ext_trig = 1'b1;
        @(negedge clk);
        ext_trig = 1'b0;
        repeat (2) @(negedge clk);
        send_bytes(rx, 0, 1);
        for (int b = 1; b < 4; b++) begin
            wait_fetch_after_ack();
            send_bytes(rx, b, 1);
        end
        wait_done_check(2, 0);

        // word mode spi to memory, bytes held off by the receive gate first
        descs = '{'{1'b1, 12'd1, 1'b1, 18'h100}, '0, '0, '0};
        reg_write(8'h80, descs[0], 4'hf);
        reg_write(8'(CTRL), make_ctrl(1, 0, 1, 0, 2'd0, 0), 4'b0011);
        u_chk.build_expect(descs, make_ctrl(1, 0, 1, 0, 2'd0, 1), rx);
        reg_write(8'(CMD), 32'(1) << CMD_SOFT_TRIG_BIT, 4'hf);
        repeat (2) @(negedge clk);
        send_bytes(junk, 0, 4);
        repeat (4) @(negedge clk);
        reg_write(8'(CTRL), make_ctrl(1, 0, 1, 0, 2'd0, 1), 4'b0011);
        send_bytes(rx, 0, 4);
        wait_fetch_after_ack();
        send_bytes(rx, 4, 4);
        wait_done_check(3, 0);

        // counter clear
        reg_write(8'(RUN_COUNT), 32'h0, 4'hf);
        reg_read(8'(RUN_COUNT), rd);
        u_chk.compare_value("RUN_COUNT", rd, 32'h0);

        repeat (4) @(negedge clk);
        if (u_chk.report_errors() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- verilog/descriptor_ram.sv
module descriptor_ram #(
    parameter int DESC_IDX_W = 5
) (
    input  logic                   fast_clk_i,
    input  logic [3:0]             we_i,
    input  logic [DESC_IDX_W-1:0]  waddr_i,
    input  logic [31:0]            wdata_i,
    input  logic [DESC_IDX_W-1:0]  raddr_i,
    output dma_reg_pkg::dma_desc_t rdata_o
);
    logic [31:0] mem [2**DESC_IDX_W];

    // byte lane writes from the host
    always_ff @(posedge fast_clk_i) begin
        for (int i = 0; i < 4; i++) begin
            if (we_i[i]) begin
                mem[waddr_i][8*i +: 8] <= wdata_i[8*i +: 8];
            end
        end
    end

    // read is combinational, shared by host and engine
    assign rdata_o = mem[raddr_i];

endmodule

//--- verilog/dma_addr_gen.sv
module dma_addr_gen (
    input  logic                                fast_clk_i,
    input  dma_engine_pkg::seq_state_e          state_i,
    input  dma_reg_pkg::dma_desc_t              desc_i,
    input  logic [dma_reg_pkg::DESC_LEN_W-1:0]  beat_i,
    input  dma_reg_pkg::dma_ctrl_t              ctrl_i,
    output logic [dma_reg_pkg::DESC_ADDR_W-1:0] addr_o,
    output logic [3:0]                          sel_o
);
    import dma_reg_pkg::*;
    import dma_engine_pkg::*;

    // address and select are fixed for the whole beat, so latch them in decode
    always_ff @(posedge fast_clk_i) begin
        if (state_i == DECODE) begin
            // fixed address mode hits the base every beat
            addr_o <= desc_i.incr ? desc_i.addr + DESC_ADDR_W'(beat_i) : desc_i.addr;
            for (int i = 0; i < 4; i++) begin
                // word mode enables all lanes, byte mode only the target
                sel_o[i] <= !ctrl_i.byte_mode || (ctrl_i.byte_target == lane_t'(i));
            end
        end
    end

endmodule

//--- verilog/dma_engine_pkg.sv
package dma_engine_pkg;

    // sequencer states
    // fetch and store states are consecutive so a lane index can be added
    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        DECODE    = 4'd1,
        FETCH_0   = 4'd2,
        FETCH_1   = 4'd3,
        FETCH_2   = 4'd4,
        FETCH_3   = 4'd5,
        BUS_WRITE = 4'd6,
        BUS_READ  = 4'd7,
        STORE_0   = 4'd8,
        STORE_1   = 4'd9,
        STORE_2   = 4'd10,
        STORE_3   = 4'd11,
        NEXT      = 4'd12,
        DONE      = 4'd13
    } seq_state_e;

    // memory bus request, held until ack
    typedef struct packed {
        logic                               req;
        logic                               we;
        logic [3:0]                         sel;
        logic [dma_reg_pkg::DESC_ADDR_W-1:0] addr;
        logic [31:0]                        wdata;
    } mem_req_t;

    // byte lane within the 32-bit word
    typedef logic [1:0] lane_t;

endpackage

//--- verilog/dma_reg_file.sv
module dma_reg_file #(
    parameter int DESC_IDX_W = 5
) (
    input  logic                               fast_clk_i,
    input  logic                               dma_engine_reset,
    input  logic                               reg_wr_i,
    input  logic                               reg_rd_i,
    input  logic [dma_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [31:0]                        reg_wdata_i,
    input  logic [3:0]                         reg_be_i,
    input  logic                               ext_trig_i,
    input  logic                               done_i,
    input  logic [DESC_IDX_W-1:0]              desc_idx_i,
    input  dma_reg_pkg::dma_desc_t             desc_rdata_i,
    output logic [31:0]                        reg_rdata_o,
    output dma_reg_pkg::dma_ctrl_t             ctrl_o,
    output logic                               run_o,
    output logic                               dma_rdy_o,
    output logic [3:0]                         desc_we_o,
    output logic [DESC_IDX_W-1:0]              desc_addr_o
);
    import dma_reg_pkg::*;

    dma_ctrl_t   ctrl_q;
    dma_ctrl_t   wr_word;
    logic        run_q;
    logic [31:0] run_count_q;
    reg_sel_e    sel;
    logic        ctrl_space;
    logic        soft_trig;
    logic        trig;
    logic        cnt_clr;

    // address decode, bit 7 low means control space
    assign sel        = reg_sel_e'(reg_addr_i[1:0]);
    assign ctrl_space = !reg_addr_i[REG_ADDR_W-1];
    assign wr_word    = dma_ctrl_t'(reg_wdata_i);
    assign cnt_clr    = reg_wr_i && ctrl_space && (sel == RUN_COUNT);

    // soft trigger is a one cycle strobe straight off the command write
    assign soft_trig = reg_wr_i && ctrl_space && (sel == CMD) && reg_be_i[0] &&
                       reg_wdata_i[CMD_SOFT_TRIG_BIT];
    assign trig      = soft_trig || (ext_trig_i && ctrl_q.ext_trig_en);

    // descriptor writes carry the host byte enables
    assign desc_we_o = (reg_wr_i && !ctrl_space) ? reg_be_i : 4'b0000;

    // engine owns the read port while enabled
    assign desc_addr_o = ctrl_q.enable ? desc_idx_i : reg_addr_i[DESC_IDX_W-1:0];

    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            ctrl_q <= '0;
        end else if (reg_wr_i && ctrl_space && (sel == CTRL)) begin
            // low byte holds the mode bits
            if (reg_be_i[0]) begin
                ctrl_q.enable      <= wr_word.enable;
                ctrl_q.ext_trig_en <= wr_word.ext_trig_en;
                ctrl_q.dir         <= wr_word.dir;
                ctrl_q.byte_mode   <= wr_word.byte_mode;
                ctrl_q.byte_target <= wr_word.byte_target;
            end
            if (reg_be_i[1]) begin
                ctrl_q.rx_en <= wr_word.rx_en;
            end
        end
    end

    // run flag, set by a trigger while enabled, dropped when the sequencer finishes
    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            run_q <= 1'b0;
        end else if (done_i) begin
            run_q <= 1'b0;
        end else if (ctrl_q.enable && trig) begin
            run_q <= 1'b1;
        end
    end

    // completed runs, any write clears
    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset || cnt_clr) begin
            run_count_q <= '0;
        end else if (done_i) begin
            run_count_q <= run_count_q + 1'b1;
        end
    end

    // readback lands one cycle after the read strobe
    always_ff @(posedge fast_clk_i) begin
        if (reg_rd_i) begin
            if (!ctrl_space) begin
                reg_rdata_o <= desc_rdata_i;
            end else begin
                case (sel)
                    CTRL:      reg_rdata_o <= ctrl_o;
                    CUR_DESC:  reg_rdata_o <= 32'(desc_idx_i);
                    RUN_COUNT: reg_rdata_o <= run_count_q;
                    // command bits are write only
                    default:   reg_rdata_o <= '0;
                endcase
            end
        end
    end

    always_comb begin
        ctrl_o         = ctrl_q;
        ctrl_o.running = run_q;
    end

    assign run_o     = run_q;
    assign dma_rdy_o = ctrl_q.enable && ctrl_q.ext_trig_en && !run_q;

endmodule

//--- verilog/dma_reg_pkg.sv
package dma_reg_pkg;

    // host address width, top bit picks descriptor space
    localparam int REG_ADDR_W = 8;

    // descriptor field widths
    localparam int DESC_ADDR_W = 18;
    localparam int DESC_LEN_W  = 12;

    // control space registers, picked by address bits 1:0
    typedef enum logic [1:0] {
        CTRL      = 2'd0,
        CMD       = 2'd1,
        CUR_DESC  = 2'd2,
        RUN_COUNT = 2'd3
    } reg_sel_e;

    // command register bit that fires a soft trigger
    localparam int CMD_SOFT_TRIG_BIT = 3;

    // control word, bit 0 at the bottom
    typedef struct packed {
        logic [22:0] rsvd_hi;
        logic        rx_en;
        logic [1:0]  byte_target;
        logic        byte_mode;
        logic        rsvd_4;
        // 1 moves spi bytes into memory
        logic        dir;
        logic        ext_trig_en;
        // mirrors the run flag, not writable
        logic        running;
        logic        enable;
    } dma_ctrl_t;

    // one descriptor word, beats = len + 1
    typedef struct packed {
        logic                   last;
        logic [DESC_LEN_W-1:0]  len;
        logic                   incr;
        logic [DESC_ADDR_W-1:0] addr;
    } dma_desc_t;

endpackage

//--- verilog/dma_sequencer.sv
module dma_sequencer #(
    parameter int DESC_IDX_W = 5
) (
    input  logic                               fast_clk_i,
    input  logic                               dma_engine_reset,
    input  logic                               run_i,
    input  dma_reg_pkg::dma_ctrl_t             ctrl_i,
    input  dma_reg_pkg::dma_desc_t             desc_i,
    input  logic                               mem_ack_i,
    input  logic                               rx_valid_i,
    output dma_engine_pkg::seq_state_e         state_o,
    output logic [dma_reg_pkg::DESC_LEN_W-1:0] beat_o,
    output logic [DESC_IDX_W-1:0]              desc_idx_o,
    output logic                               mem_req_o,
    output logic                               mem_we_o,
    output logic                               tx_valid_o,
    output logic                               done_o
);
    import dma_engine_pkg::*;

    seq_state_e              state_q;
    seq_state_e              state_d;
    logic [$bits(beat_o)-1:0] beat_q;
    logic [DESC_IDX_W-1:0]   desc_idx_q;
    lane_t                   first_lane;
    lane_t                   cur_lane;
    logic                    is_fetch;
    logic                    lane_last;
    logic                    rx_accept;
    logic                    desc_end;

    always_comb begin
        is_fetch   = state_q inside {FETCH_0, FETCH_1, FETCH_2, FETCH_3};
        // byte mode jumps straight to the target lane
        first_lane = ctrl_i.byte_mode ? ctrl_i.byte_target : lane_t'(0);
        cur_lane   = is_fetch ? lane_t'(state_q - FETCH_0) : lane_t'(state_q - STORE_0);
        // a byte transfer is always one lane long
        lane_last  = ctrl_i.byte_mode || (cur_lane == lane_t'(3));
        rx_accept  = is_fetch && rx_valid_i && ctrl_i.rx_en;
        desc_end   = (beat_q == desc_i.len);

        state_d = state_q;
        case (state_q)
            IDLE:      if (run_i) state_d = DECODE;
            DECODE:    state_d = ctrl_i.dir ? seq_state_e'(FETCH_0 + first_lane) : BUS_READ;
            FETCH_0, FETCH_1, FETCH_2, FETCH_3: begin
                if (rx_accept) begin
                    state_d = lane_last ? BUS_WRITE : seq_state_e'(state_q + 4'd1);
                end
            end
            BUS_WRITE: if (mem_ack_i) state_d = NEXT;
            BUS_READ:  if (mem_ack_i) state_d = seq_state_e'(STORE_0 + first_lane);
            // one transmit byte per cycle, no back-pressure
            STORE_0, STORE_1, STORE_2, STORE_3: begin
                state_d = lane_last ? NEXT : seq_state_e'(state_q + 4'd1);
            end
            NEXT:      state_d = (desc_end && desc_i.last) ? DONE : DECODE;
            DONE:      state_d = IDLE;
            default:   state_d = IDLE;
        endcase
    end

    always_ff @(posedge fast_clk_i) begin
        if (dma_engine_reset) begin
            state_q    <= IDLE;
            beat_q     <= '0;
            desc_idx_q <= '0;
        end else begin
            state_q <= state_d;
            // counters restart with each run and hold their final values afterwards
            if (state_q == IDLE && run_i) begin
                beat_q     <= '0;
                desc_idx_q <= '0;
            end else if (state_q == NEXT) begin
                if (desc_end) begin
                    beat_q <= '0;
                    // chain onward unless this was the last descriptor
                    if (!desc_i.last) begin
                        desc_idx_q <= desc_idx_q + 1'b1;
                    end
                end else begin
                    beat_q <= beat_q + 1'b1;
                end
            end
        end
    end

    assign state_o    = state_q;
    assign beat_o     = beat_q;
    assign desc_idx_o = desc_idx_q;
    assign mem_req_o  = (state_q == BUS_WRITE) || (state_q == BUS_READ);
    assign mem_we_o   = (state_q == BUS_WRITE);
    assign tx_valid_o = state_q inside {STORE_0, STORE_1, STORE_2, STORE_3};
    assign done_o     = (state_q == DONE);

endmodule

//--- verilog/dma_spi_top.sv
module dma_spi_top #(
    parameter int DESC_IDX_W = 5
) (
    input  logic                               fast_clk_i,
    input  logic                               dma_engine_reset,
    input  logic                               reg_wr_i,
    input  logic                               reg_rd_i,
    input  logic [dma_reg_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [31:0]                        reg_wdata_i,
    input  logic [3:0]                         reg_be_i,
    output logic [31:0]                        reg_rdata_o,
    input  logic                               ext_trig_i,
    output logic                               dma_rdy_o,
    output dma_engine_pkg::mem_req_t           mem_req_o,
    input  logic                               mem_ack_i,
    input  logic [31:0]                        mem_rdata_i,
    output logic                               tx_valid_o,
    output logic [7:0]                         tx_data_o,
    input  logic                               rx_valid_i,
    input  logic [7:0]                         rx_data_i,
    output logic                               done_o
);
    import dma_reg_pkg::*;
    import dma_engine_pkg::*;

    // control word and run flag from the register file
    dma_ctrl_t ctrl;
    logic      run;

    // descriptor ram hookup
    logic [3:0]            desc_we;
    logic [DESC_IDX_W-1:0] desc_raddr;
    dma_desc_t             desc;

    // sequencer status
    seq_state_e            state;
    logic [DESC_LEN_W-1:0] beat;
    logic [DESC_IDX_W-1:0] desc_idx;
    logic                  seq_req;
    logic                  seq_we;

    // bus payload
    logic [31:0]            wdata;
    logic [DESC_ADDR_W-1:0] addr;
    logic [3:0]             sel;

    dma_reg_file #(
        .DESC_IDX_W(DESC_IDX_W)
    ) u_reg_file (
        .fast_clk_i      (fast_clk_i),
        .dma_engine_reset(dma_engine_reset),
        .reg_wr_i        (reg_wr_i),
        .reg_rd_i        (reg_rd_i),
        .reg_addr_i      (reg_addr_i),
        .reg_wdata_i     (reg_wdata_i),
        .reg_be_i        (reg_be_i),
        .ext_trig_i      (ext_trig_i),
        .done_i          (done_o),
        .desc_idx_i      (desc_idx),
        .desc_rdata_i    (desc),
        .reg_rdata_o     (reg_rdata_o),
        .ctrl_o          (ctrl),
        .run_o           (run),
        .dma_rdy_o       (dma_rdy_o),
        .desc_we_o       (desc_we),
        .desc_addr_o     (desc_raddr)
    );

    // host always writes at its own address, reads follow the engine when enabled
    descriptor_ram #(
        .DESC_IDX_W(DESC_IDX_W)
    ) u_desc_ram (
        .fast_clk_i(fast_clk_i),
        .we_i      (desc_we),
        .waddr_i   (reg_addr_i[DESC_IDX_W-1:0]),
        .wdata_i   (reg_wdata_i),
        .raddr_i   (desc_raddr),
        .rdata_o   (desc)
    );

    dma_sequencer #(
        .DESC_IDX_W(DESC_IDX_W)
    ) u_sequencer (
        .fast_clk_i      (fast_clk_i),
        .dma_engine_reset(dma_engine_reset),
        .run_i           (run),
        .ctrl_i          (ctrl),
        .desc_i          (desc),
        .mem_ack_i       (mem_ack_i),
        .rx_valid_i      (rx_valid_i),
        .state_o         (state),
        .beat_o          (beat),
        .desc_idx_o      (desc_idx),
        .mem_req_o       (seq_req),
        .mem_we_o        (seq_we),
        .tx_valid_o      (tx_valid_o),
        .done_o          (done_o)
    );

    dma_word_lane u_word_lane (
        .fast_clk_i (fast_clk_i),
        .state_i    (state),
        .rx_valid_i (rx_valid_i),
        .rx_data_i  (rx_data_i),
        .mem_ack_i  (mem_ack_i),
        .mem_rdata_i(mem_rdata_i),
        .wdata_o    (wdata),
        .tx_data_o  (tx_data_o)
    );

    dma_addr_gen u_addr_gen (
        .fast_clk_i(fast_clk_i),
        .state_i   (state),
        .desc_i    (desc),
        .beat_i    (beat),
        .ctrl_i    (ctrl),
        .addr_o    (addr),
        .sel_o     (sel)
    );

    assign mem_req_o = '{req: seq_req, we: seq_we, sel: sel, addr: addr, wdata: wdata};

endmodule

//--- verilog/dma_word_lane.sv
module dma_word_lane (
    input  logic                       fast_clk_i,
    input  dma_engine_pkg::seq_state_e state_i,
    input  logic                       rx_valid_i,
    input  logic [7:0]                 rx_data_i,
    input  logic                       mem_ack_i,
    input  logic [31:0]                mem_rdata_i,
    output logic [31:0]                wdata_o,
    output logic [7:0]                 tx_data_o
);
    import dma_engine_pkg::*;

    logic [31:0] data_q;
    lane_t       fetch_lane;
    lane_t       store_lane;
    logic        is_fetch;

    always_comb begin
        is_fetch   = state_i inside {FETCH_0, FETCH_1, FETCH_2, FETCH_3};
        fetch_lane = lane_t'(state_i - FETCH_0);
        store_lane = lane_t'(state_i - STORE_0);
    end

    // read data lands whole, received bytes land in the lane of the fetch state
    // a dropped byte can only hit the current lane, and the accepted byte overwrites it
    always_ff @(posedge fast_clk_i) begin
        if (state_i == BUS_READ && mem_ack_i) begin
            data_q <= mem_rdata_i;
        end else if (is_fetch && rx_valid_i) begin
            data_q[8*fetch_lane +: 8] <= rx_data_i;
        end
    end

    assign wdata_o   = data_q;
    // only meaningful in store states
    assign tx_data_o = data_q[8*store_lane +: 8];

endmodule
